// ==== design/controller_port_top.sv ====
`timescale 1ns/100ps

module controller_port_top import pce_pad_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,

	// Console side
	input  logic                   port_sel,
	input  logic                   port_clr,
	output logic [NIBBLE_W-1:0]    port_data,

	// Host pads
	input  logic [PAD_W-1:0]       pad_0,
	input  logic [PAD_W-1:0]       pad_1,
	input  logic [PAD_W-1:0]       pad_2,
	input  logic [PAD_W-1:0]       pad_3,
	input  logic [PAD_W-1:0]       pad_4,

	input  logic [MOUSE_REC_W-1:0] mouse_rec,

	// Modes
	input  logic                   multitap_en,
	input  logic                   six_button_en,
	input  logic                   mouse_en
);

	logic [PORT_IDX_W-1:0] port_idx;
	logic                  page_high;
	logic                  port_active;
	logic                  clr_rise;
	logic [NIBBLE_W-1:0]   mouse_nibble;

	multitap_scanner u_scanner (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.port_sel      (port_sel),
		.port_clr      (port_clr),
		.multitap_en   (multitap_en),
		.six_button_en (six_button_en),
		.port_idx      (port_idx),
		.page_high     (page_high),
		.port_active   (port_active),
		.clr_rise      (clr_rise)
	);

	mouse_tracker u_mouse (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.port_clr     (port_clr),
		.clr_rise     (clr_rise),
		.mouse_rec    (mouse_rec),
		.mouse_nibble (mouse_nibble)
	);

	port_nibble_mux u_mux (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.port_sel     (port_sel),
		.port_idx     (port_idx),
		.page_high    (page_high),
		.port_active  (port_active),
		.pad_0        (pad_0),
		.pad_1        (pad_1),
		.pad_2        (pad_2),
		.pad_3        (pad_3),
		.pad_4        (pad_4),
		.mouse_en     (mouse_en),
		.mouse_rec    (mouse_rec),
		.mouse_nibble (mouse_nibble),
		.port_data    (port_data)
	);

endmodule

// ==== design/mouse_tracker.sv ====
`timescale 1ns/100ps

module mouse_tracker import pce_pad_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,

	input  logic                   port_clr,
	input  logic                   clr_rise,

	// Host mouse record, strobe toggles per sample
	input  logic [MOUSE_REC_W-1:0] mouse_rec,

	output logic [NIBBLE_W-1:0]    mouse_nibble
);

	logic                     stb_prev;
	logic                     stb_toggle;
	logic                     latch;

	logic [MOUSE_DELTA_W-1:0] pend_x;
	logic [MOUSE_DELTA_W-1:0] pend_y;
	logic [MOUSE_DELTA_W-1:0] cur_x;
	logic [MOUSE_DELTA_W-1:0] cur_y;

	logic [MOUSE_IDLE_W-1:0]  idle_cnt;
	logic [1:0]               seq_cnt;

	logic [MOUSE_DELTA_W-1:0] rec_dx;
	logic [MOUSE_DELTA_W-1:0] rec_dy;

	assign rec_dx     = mouse_rec[MREC_DX_LSB +: MOUSE_DELTA_W];
	assign rec_dy     = mouse_rec[MREC_DY_LSB +: MOUSE_DELTA_W];
	assign stb_toggle = stb_prev ^ mouse_rec[MREC_STB];

	// Pending motion moves to the output after the fourth read
	assign latch = clr_rise && (seq_cnt == 2'd3);

	////////////////////////////////////////////////////////////
	// Idle timeout and read sequence
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			idle_cnt <= '0;
			seq_cnt  <= 2'd3;
		end else begin
			if (port_clr)
				idle_cnt <= '0;
			else if (~&idle_cnt)
				idle_cnt <= idle_cnt + MOUSE_IDLE_W'(1);

			// Long quiet port restarts the sequence on the next CLR
			if (&idle_cnt)
				seq_cnt <= 2'd3;
			if (clr_rise)
				seq_cnt <= seq_cnt + 2'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Motion capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// Follow the current strobe so reset does not look like a sample
			stb_prev <= mouse_rec[MREC_STB];
			pend_x   <= '0;
			pend_y   <= '0;
			cur_x    <= '0;
			cur_y    <= '0;
		end else begin
			stb_prev <= mouse_rec[MREC_STB];

			if (latch) begin
				cur_x  <= pend_x;
				cur_y  <= pend_y;
				pend_x <= '0;
				pend_y <= '0;
			end

			// New sample overwrites, x axis is reversed for the console
			if (stb_toggle) begin
				pend_x <= MOUSE_DELTA_W'(0) - rec_dx;
				pend_y <= rec_dy;
			end
		end
	end

	// High nibble first, x before y
	always_comb begin
		case (seq_cnt)
			2'd0:    mouse_nibble = cur_x[7:4];
			2'd1:    mouse_nibble = cur_x[3:0];
			2'd2:    mouse_nibble = cur_y[7:4];
			default: mouse_nibble = cur_y[3:0];
		endcase
	end

	a_pending_cleared: assert property (
		@(posedge clk_sys) disable iff (reset)
		(latch && !stb_toggle) |=> (pend_x == '0 && pend_y == '0)
	);

endmodule

// ==== design/multitap_scanner.sv ====
`timescale 1ns/100ps

module multitap_scanner import pce_pad_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,

	// Console port lines
	input  logic                  port_sel,
	input  logic                  port_clr,

	// Mode levels
	input  logic                  multitap_en,
	input  logic                  six_button_en,

	output logic [PORT_IDX_W-1:0] port_idx,
	output logic                  page_high,
	output logic                  port_active,
	output logic                  clr_rise
);

	logic prev_sel;
	logic prev_clr;
	logic sel_edge;
	logic clr_edge;

	assign sel_edge = port_sel & ~prev_sel;
	assign clr_edge = port_clr & ~prev_clr;

	////////////////////////////////////////////////////////////
	// Line history and edge pulse
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			prev_sel <= 1'b0;
			prev_clr <= 1'b0;
			clr_rise <= 1'b0;
		end else begin
			prev_sel <= port_sel;
			prev_clr <= port_clr;
			clr_rise <= clr_edge;
		end
	end

	////////////////////////////////////////////////////////////
	// Port index, page and idle flag
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_idx    <= '0;
			page_high   <= 1'b0;
			port_active <= 1'b0;
		end else begin
			// Port goes quiet while CLR is held
			port_active <= ~port_clr;

			if (port_clr) begin
				port_idx <= '0;
				// Six-button pads flip page on every CLR pulse
				if (clr_edge)
					page_high <= ~page_high & six_button_en;
			end else if (sel_edge && multitap_en) begin
				port_idx <= port_idx + PORT_IDX_W'(1);
			end
		end
	end

	// Each CLR edge gives exactly one single-cycle pulse
	a_clr_rise_single: assert property (
		@(posedge clk_sys) disable iff (reset)
		clr_rise |=> !clr_rise
	);

endmodule

// ==== design/pce_pad_pkg.sv ====
package pce_pad_pkg;

	////////////////////////////////////////////////////////////
	// Port geometry
	////////////////////////////////////////////////////////////

	localparam int NUM_PADS    = 5;
	localparam int PORT_IDX_W  = 3;
	localparam int PAD_W       = 12;
	localparam int PORT_WORD_W = 16;
	localparam int NIBBLE_W    = 4;

	// Nibble slots inside a port word, picked by {page_high, SEL}
	localparam int NIBBLE_IDX_W = 2;
	localparam logic [NIBBLE_IDX_W-1:0] NIB_BUTTONS  = 2'd0;
	localparam logic [NIBBLE_IDX_W-1:0] NIB_DIRS     = 2'd1;
	localparam logic [NIBBLE_IDX_W-1:0] NIB_EXTRA    = 2'd2;
	localparam logic [NIBBLE_IDX_W-1:0] NIB_RESERVED = 2'd3;

	// Nothing plugged in past the last multitap port
	localparam logic [PORT_WORD_W-1:0] EMPTY_PORT_WORD = 16'h0FFF;

	// Host pad word bits
	localparam int PAD_RIGHT   = 0;
	localparam int PAD_LEFT    = 1;
	localparam int PAD_DOWN    = 2;
	localparam int PAD_UP      = 3;
	localparam int PAD_I       = 4;
	localparam int PAD_II      = 5;
	localparam int PAD_SEL     = 6;
	localparam int PAD_RUN     = 7;
	localparam int PAD_EXT_LSB = 8;

	////////////////////////////////////////////////////////////
	// Mouse record
	////////////////////////////////////////////////////////////

	localparam int MOUSE_DELTA_W = 8;
	localparam int MOUSE_REC_W   = 25;
	localparam int MREC_BTN_L    = 0;
	localparam int MREC_BTN_R    = 1;
	localparam int MREC_DX_LSB   = 8;
	localparam int MREC_DY_LSB   = 16;
	localparam int MREC_STB      = 24;

	// Idle counter saturates at all ones (32767 cycles)
	localparam int MOUSE_IDLE_W = 15;

endpackage

// ==== design/port_nibble_mux.sv ====
`timescale 1ns/100ps

module port_nibble_mux import pce_pad_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,

	input  logic                   port_sel,
	input  logic [PORT_IDX_W-1:0]  port_idx,
	input  logic                   page_high,
	input  logic                   port_active,

	input  logic [PAD_W-1:0]       pad_0,
	input  logic [PAD_W-1:0]       pad_1,
	input  logic [PAD_W-1:0]       pad_2,
	input  logic [PAD_W-1:0]       pad_3,
	input  logic [PAD_W-1:0]       pad_4,

	input  logic                   mouse_en,
	input  logic [MOUSE_REC_W-1:0] mouse_rec,
	input  logic [NIBBLE_W-1:0]    mouse_nibble,

	output logic [NIBBLE_W-1:0]    port_data
);

	// Active-low pad word, buttons in the lowest nibble
	function automatic logic [PORT_WORD_W-1:0] pad_word(input logic [PAD_W-1:0] pad);
		logic [PORT_WORD_W-1:0] w;
		w = '0;
		w[NIB_BUTTONS*NIBBLE_W +: NIBBLE_W] =
			~{pad[PAD_RUN], pad[PAD_SEL], pad[PAD_II], pad[PAD_I]};
		w[NIB_DIRS*NIBBLE_W +: NIBBLE_W] =
			~{pad[PAD_LEFT], pad[PAD_DOWN], pad[PAD_RIGHT], pad[PAD_UP]};
		w[NIB_EXTRA*NIBBLE_W +: NIBBLE_W] = ~pad[PAD_EXT_LSB +: NIBBLE_W];
		w[NIB_RESERVED*NIBBLE_W +: NIBBLE_W] = '0;
		return w;
	endfunction

	logic [PAD_W-1:0]        pads [NUM_PADS];
	logic [2*NIBBLE_W-1:0]   mouse_byte;
	logic [PORT_WORD_W-1:0]  port_word;
	logic [NIBBLE_IDX_W-1:0] nib_sel;

	assign pads[0] = pad_0;
	assign pads[1] = pad_1;
	assign pads[2] = pad_2;
	assign pads[3] = pad_3;
	assign pads[4] = pad_4;

	// Mouse low nibble: left, right, select, run
	assign mouse_byte = {mouse_nibble,
		~{pad_0[PAD_RUN], pad_0[PAD_SEL], mouse_rec[MREC_BTN_R], mouse_rec[MREC_BTN_L]}};

	always_comb begin
		if (port_idx == '0 && mouse_en)
			port_word = {mouse_byte, mouse_byte};
		else if (port_idx < PORT_IDX_W'(NUM_PADS))
			port_word = pad_word(pads[port_idx]);
		else
			port_word = EMPTY_PORT_WORD;
	end

	assign nib_sel = {page_high, port_sel};

	always_ff @(posedge clk_sys) begin
		if (reset)
			port_data <= '0;
		else if (port_active)
			port_data <= port_word[nib_sel*NIBBLE_W +: NIBBLE_W];
		else
			port_data <= '0;
	end

	a_idle_port_zero: assert property (
		@(posedge clk_sys) disable iff (reset)
		!port_active |=> (port_data == '0)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the controller port testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"

verilator --binary --timing --assert \
	--top-module tb_controller_port \
	-f sources.f \
	--Mdir "$BUILD_DIR/obj_dir" \
	-o sim_controller_port

"./$BUILD_DIR/obj_dir/sim_controller_port" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -q "^TEST PASSED$" "$LOG_FILE"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG_FILE"
	exit 1
fi

// ==== sim/tb_controller_port.sv ====
`timescale 1ns/100ps

module tb_controller_port import pce_pad_pkg::*; ();

	localparam int CLK_PERIOD_NS    = 10;
	localparam int IDLE_WAIT_CYCLES = 33000;
	localparam int DIRECTED_CYCLES  = 4000;
	localparam int WATCHDOG_NS      = (IDLE_WAIT_CYCLES + DIRECTED_CYCLES) * CLK_PERIOD_NS * 100;
	localparam logic [31:0] SEED    = 32'hbf5b_7dda;

	logic                   clk_sys;
	logic                   reset;
	logic                   port_sel;
	logic                   port_clr;
	logic [NIBBLE_W-1:0]    port_data;
	logic [PAD_W-1:0]       pad_0;
	logic [PAD_W-1:0]       pad_1;
	logic [PAD_W-1:0]       pad_2;
	logic [PAD_W-1:0]       pad_3;
	logic [PAD_W-1:0]       pad_4;
	logic [MOUSE_REC_W-1:0] mouse_rec;
	logic                   multitap_en;
	logic                   six_button_en;
	logic                   mouse_en;

	// Expected port state, stepped from the port line rules
	logic [PORT_IDX_W-1:0]  exp_port;
	logic                   exp_page;
	logic [NIBBLE_W-1:0]    exp_motion;
	logic [PAD_W-1:0]       pad_words [NUM_PADS];
	int                     error_count;

	controller_port_top u_dut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.port_sel      (port_sel),
		.port_clr      (port_clr),
		.port_data     (port_data),
		.pad_0         (pad_0),
		.pad_1         (pad_1),
		.pad_2         (pad_2),
		.pad_3         (pad_3),
		.pad_4         (pad_4),
		.mouse_rec     (mouse_rec),
		.multitap_en   (multitap_en),
		.six_button_en (six_button_en),
		.mouse_en      (mouse_en)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the directed tests did not finish in %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Reference model and checking
	////////////////////////////////////////////////////////////

	function automatic logic [NIBBLE_W-1:0] expected_nibble(
		input logic                  active,
		input logic [PORT_IDX_W-1:0] port,
		input logic                  page,
		input logic                  sel,
		input logic [PAD_W-1:0]      pad,
		input logic                  mouse_on,
		input logic                  btn_l,
		input logic                  btn_r,
		input logic [NIBBLE_W-1:0]   motion
	);
		logic [NIBBLE_W-1:0] nib;
		nib = '0;
		if (!active) begin
			nib = '0;
		end else if (port == '0 && mouse_on) begin
			if (sel) begin
				nib = motion;
			end else begin
				nib[0] = ~btn_l;
				nib[1] = ~btn_r;
				nib[2] = ~pad[PAD_SEL];
				nib[3] = ~pad[PAD_RUN];
			end
		end else if (port >= PORT_IDX_W'(NUM_PADS)) begin
			// Empty slot reads 0FFF
			nib = (page && sel) ? 4'h0 : 4'hF;
		end else if (!page && !sel) begin
			nib[0] = ~pad[PAD_I];
			nib[1] = ~pad[PAD_II];
			nib[2] = ~pad[PAD_SEL];
			nib[3] = ~pad[PAD_RUN];
		end else if (!page && sel) begin
			nib[0] = ~pad[PAD_UP];
			nib[1] = ~pad[PAD_RIGHT];
			nib[2] = ~pad[PAD_DOWN];
			nib[3] = ~pad[PAD_LEFT];
		end else if (!sel) begin
			nib = ~pad[11:8];
		end else begin
			nib = '0;
		end
		return nib;
	endfunction

	task automatic check_value(input logic [NIBBLE_W-1:0] got, input logic [NIBBLE_W-1:0] exp,
		input string what);
		if (got !== exp) begin
			error_count++;
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	// Drive SEL and CLR, stepping the expected port index and page
	task automatic drive_lines(input logic sel, input logic clr);
		@(posedge clk_sys);
		if (clr) begin
			exp_port = '0;
			if (!port_clr)
				exp_page = six_button_en ? ~exp_page : 1'b0;
		end else if (sel && !port_sel && multitap_en) begin
			exp_port = exp_port + PORT_IDX_W'(1);
		end
		port_sel <= sel;
		port_clr <= clr;
	endtask

	task automatic pulse_clr();
		drive_lines(1'b1, 1'b1);
		wait_cycles(2);
		drive_lines(1'b1, 1'b0);
	endtask

	task automatic set_modes(input logic multitap, input logic six_button, input logic mouse);
		@(posedge clk_sys);
		multitap_en   <= multitap;
		six_button_en <= six_button;
		mouse_en      <= mouse;
	endtask

	task automatic set_random_pads();
		@(posedge clk_sys);
		for (int i = 0; i < NUM_PADS; i++)
			pad_words[i] = PAD_W'($urandom);
		pad_0 <= pad_words[0];
		pad_1 <= pad_words[1];
		pad_2 <= pad_words[2];
		pad_3 <= pad_words[3];
		pad_4 <= pad_words[4];
	endtask

	// Let the change reach port_data, then sample away from the edge
	task automatic read_port(input string what);
		logic [PAD_W-1:0]    pad;
		logic [NIBBLE_W-1:0] exp;
		wait_cycles(4);
		@(negedge clk_sys);
		pad = (exp_port < PORT_IDX_W'(NUM_PADS)) ? pad_words[exp_port] : '0;
		exp = expected_nibble(!port_clr, exp_port, exp_page, port_sel, pad, mouse_en,
			mouse_rec[MREC_BTN_L], mouse_rec[MREC_BTN_R], exp_motion);
		check_value(port_data, exp, what);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_idle();
		@(negedge clk_sys);
		check_value(port_data, '0, "port_data after reset");
		drive_lines(1'b0, 1'b1);
		for (int i = 0; i < 4; i++) begin
			set_random_pads();
			read_port($sformatf("CLR high, SEL low, round %0d", i));
			drive_lines(1'b1, 1'b1);
			read_port($sformatf("CLR high, SEL high, round %0d", i));
			drive_lines(1'b0, 1'b1);
		end
	endtask

	task automatic test_single_pad();
		set_modes(1'b0, 1'b0, 1'b0);
		drive_lines(1'b0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			set_random_pads();
			read_port($sformatf("single pad buttons, round %0d", i));
			drive_lines(1'b1, 1'b0);
			read_port($sformatf("single pad directions, round %0d", i));
			drive_lines(1'b0, 1'b0);
		end
	endtask

	task automatic test_multitap();
		set_modes(1'b1, 1'b0, 1'b0);
		set_random_pads();
		pulse_clr();
		// Ports 5 and 6 sit past the last pad
		for (int p = 0; p < 7; p++) begin
			read_port($sformatf("multitap port %0d directions", p));
			drive_lines(1'b0, 1'b0);
			read_port($sformatf("multitap port %0d buttons", p));
			drive_lines(1'b1, 1'b0);
		end
		pulse_clr();
		read_port("multitap back to port 0");
		set_modes(1'b0, 1'b0, 1'b0);
		pulse_clr();
	endtask

	task automatic test_six_button();
		set_modes(1'b0, 1'b1, 1'b0);
		for (int i = 0; i < 4; i++) begin
			set_random_pads();
			pulse_clr();
			read_port($sformatf("six-button page %0d, SEL high", exp_page));
			drive_lines(1'b0, 1'b0);
			read_port($sformatf("six-button page %0d, SEL low", exp_page));
		end
		set_modes(1'b0, 1'b0, 1'b0);
		pulse_clr();
	endtask

	task automatic test_mouse();
		logic [MOUSE_DELTA_W-1:0] dx;
		logic [MOUSE_DELTA_W-1:0] dy;
		logic [MOUSE_DELTA_W-1:0] neg_dx;
		logic [NIBBLE_W-1:0]      seq [4];
		set_modes(1'b0, 1'b0, 1'b1);
		set_random_pads();
		drive_lines(1'b1, 1'b0);
		// Long quiet port restarts the mouse read sequence
		wait_cycles(IDLE_WAIT_CYCLES);

		dx     = MOUSE_DELTA_W'($urandom);
		dy     = MOUSE_DELTA_W'($urandom);
		neg_dx = ~dx + 8'd1;
		seq[0] = neg_dx[7:4];
		seq[1] = neg_dx[3:0];
		seq[2] = dy[7:4];
		seq[3] = dy[3:0];
		@(posedge clk_sys);
		mouse_rec <= {~mouse_rec[MREC_STB], dy, dx, 6'b0, 2'($urandom)};
		wait_cycles(4);

		for (int k = 0; k < 4; k++) begin
			pulse_clr();
			exp_motion = seq[k];
			read_port($sformatf("mouse motion read %0d", k));
			drive_lines(1'b0, 1'b0);
			read_port($sformatf("mouse buttons after read %0d", k));
		end
	endtask

	initial begin
		void'($urandom(SEED));
		reset         = 1'b1;
		port_sel      = 1'b0;
		port_clr      = 1'b0;
		pad_0         = '0;
		pad_1         = '0;
		pad_2         = '0;
		pad_3         = '0;
		pad_4         = '0;
		mouse_rec     = '0;
		multitap_en   = 1'b0;
		six_button_en = 1'b0;
		mouse_en      = 1'b0;
		exp_port      = '0;
		exp_page      = 1'b0;
		exp_motion    = '0;
		error_count   = 0;
		for (int i = 0; i < NUM_PADS; i++)
			pad_words[i] = '0;

		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		test_reset_idle();
		test_single_pad();
		test_multitap();
		test_six_button();
		test_mouse();
		wait_cycles(10);

		$display("Directed tests done, %0d errors", error_count);
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
design/pce_pad_pkg.sv
design/multitap_scanner.sv
design/mouse_tracker.sv
design/port_nibble_mux.sv
design/controller_port_top.sv
sim/tb_controller_port.sv
